// ==== compile.f ====
mod113_pkg.sv
acc_ctrl_if.sv
chunk_residue_lut.sv
word_reducer.sv
residue_accumulator.sv
residue_ctrl_regs.sv
residue_top.sv
tb_clock_gen.sv
tb_residue_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_residue_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing -j $(JOBS)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR JOBS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== tb_residue_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_residue_top
  import mod113_pkg::*;
();

  localparam int CLK_PERIOD = 4;
  localparam int N_RANDOM   = 400;
  localparam int N_CORNER   = 5 + WORD_W;
  localparam int N_MSG      = 60;
  localparam int MAX_GAP    = 3;
  localparam int MAX_LEN    = 8;
  // drain, register reads and an occasional clear per message, in cycles
  localparam int MSG_EXTRA  = 30;
  localparam int WATCHDOG_CYCLES = (N_RANDOM + N_CORNER) * (MAX_GAP + 1)
                                 + N_MSG * (MAX_LEN * (MAX_GAP + 1) + MSG_EXTRA) + 200;
  localparam int WATCHDOG_NS = WATCHDOG_CYCLES * CLK_PERIOD * 2;

  logic      clk;
  logic      reset;
  logic      in_valid;
  word_t     in_word;
  logic      in_last;
  logic      cfg_wr;
  logic      cfg_rd;
  cfg_addr_t cfg_addr;
  cfg_data_t cfg_wdata;
  logic      out_valid;
  residue_t  out_residue;
  logic      out_msg_done;
  cfg_data_t cfg_rdata;

  residue_t exp_res_q [$];
  logic     exp_done_q [$];
  int       exp_due_q [$];

  int       cyc = 0;
  int       run_res = 0;
  int       shift_res;
  logic     acc_mode = 1'b0;
  residue_t exp_result = '0;
  count_t   exp_count = '0;

  tb_clock_gen #(.PERIOD_NS (CLK_PERIOD)) clk_gen (.clk (clk));

  residue_top dut0 (
    .clk          (clk),
    .reset        (reset),
    .in_valid     (in_valid),
    .in_word      (in_word),
    .in_last      (in_last),
    .cfg_wr       (cfg_wr),
    .cfg_rd       (cfg_rd),
    .cfg_addr     (cfg_addr),
    .cfg_wdata    (cfg_wdata),
    .out_valid    (out_valid),
    .out_residue  (out_residue),
    .out_msg_done (out_msg_done),
    .cfg_rdata    (cfg_rdata)
  );

  always @(posedge clk)
    cyc <= cyc + 1;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "testbench stopped at the first error");
  endtask

  task automatic check_residue(input string name, input residue_t exp, input residue_t act);
    if (act !== exp)
      abort_run($sformatf("FAIL %s expected 0x%h got 0x%h", name, exp, act));
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
      abort_run($sformatf("FAIL %s expected 0x%h got 0x%h", name, exp, act));
  endtask

  task automatic check_rdata(input string name, input cfg_data_t exp, input cfg_data_t act);
    if (act !== exp)
      abort_run($sformatf("FAIL %s expected 0x%h got 0x%h", name, exp, act));
  endtask

  // residue by scanning the bits from the top, doubling each step
  function automatic residue_t word_mod_ref(input word_t w);
    int r;
    r = 0;
    for (int i = WORD_W - 1; i >= 0; i--)
      r = (2 * r + int'(w[i])) % int'(MODULUS);
    return residue_t'(r);
  endfunction

  function automatic int pow2_mod_ref(input int n);
    int r;
    r = 1;
    repeat (n)
      r = (2 * r) % int'(MODULUS);
    return r;
  endfunction

  function automatic word_t random_word();
    logic [127:0] raw;
    raw = {$urandom, $urandom, $urandom, $urandom};
    return raw[WORD_W-1:0];
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n)
    begin
      next_cycle();
      in_valid = 1'b0;
      in_last  = 1'b0;
    end
  endtask

  task automatic send_word(input word_t w, input logic last);
    residue_t wr;
    residue_t exp;
    logic     done;
    wr = word_mod_ref(w);
    if (acc_mode)
    begin
      // Horner step over the words of the message
      run_res = (run_res * shift_res + int'(wr)) % int'(MODULUS);
      exp     = residue_t'(run_res);
      done    = last;
      if (last)
      begin
        exp_result = exp;
        run_res    = 0;
      end
    end
    else
    begin
      exp        = wr;
      done       = 1'b0;
      exp_result = wr;
    end
    exp_count++;
    next_cycle();
    in_valid = 1'b1;
    in_word  = w;
    in_last  = last;
    exp_res_q.push_back(exp);
    exp_done_q.push_back(done);
    exp_due_q.push_back(cyc + 3);
  endtask

  task automatic drain_pipeline();
    idle_cycles(1);
    while (exp_due_q.size() != 0)
      next_cycle();
  endtask

  task automatic write_ctrl(input logic mode, input logic clear);
    next_cycle();
    cfg_wr    = 1'b1;
    cfg_addr  = ADDR_CTRL;
    cfg_wdata = {14'd0, clear, mode};
    next_cycle();
    cfg_wr   = 1'b0;
    acc_mode = mode;
    if (clear)
    begin
      exp_count  = '0;
      exp_result = '0;
      run_res    = 0;
    end
  endtask

  task automatic expect_reg(input string name, input cfg_addr_t addr, input cfg_data_t exp);
    next_cycle();
    cfg_rd   = 1'b1;
    cfg_addr = addr;
    next_cycle();
    cfg_rd = 1'b0;
    check_rdata(name, exp, cfg_rdata);
  endtask

  // outputs are compared at the falling edge, half a cycle after they change
  always @(negedge clk)
  begin
    if (!reset)
    begin
      if (out_valid)
      begin
        if (exp_due_q.size() == 0)
          abort_run("out_valid went high while no word was in flight");
        else if (exp_due_q[0] != cyc)
          abort_run($sformatf("out_valid came in cycle %0d but was due in cycle %0d",
                              cyc, exp_due_q[0]));
        else
        begin
          check_residue("out_residue", exp_res_q[0], out_residue);
          check_flag("out_msg_done", exp_done_q[0], out_msg_done);
          void'(exp_res_q.pop_front());
          void'(exp_done_q.pop_front());
          void'(exp_due_q.pop_front());
        end
      end
      else
      begin
        check_flag("out_msg_done", 1'b0, out_msg_done);
        if (exp_due_q.size() != 0 && exp_due_q[0] <= cyc)
          abort_run($sformatf("out_valid missing in cycle %0d for a word sent earlier", cyc));
      end
    end
  end

  initial
  begin
    #(WATCHDOG_NS);
    abort_run($sformatf("watchdog expired after %0d ns before the tests finished",
                        WATCHDOG_NS));
  end

  initial
  begin
    int len;
    reset     = 1'b1;
    in_valid  = 1'b0;
    in_word   = '0;
    in_last   = 1'b0;
    cfg_wr    = 1'b0;
    cfg_rd    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    void'($urandom(69));
    shift_res = pow2_mod_ref(WORD_W);
    repeat (8)
      @(posedge clk);
    #1;
    reset = 1'b0;

    check_flag("out_valid", 1'b0, out_valid);
    check_flag("out_msg_done", 1'b0, out_msg_done);
    expect_reg("cfg_rdata ctrl", ADDR_CTRL, 16'd0);
    expect_reg("cfg_rdata count", ADDR_COUNT, 16'd0);
    expect_reg("cfg_rdata result", ADDR_RESULT, 16'd0);
    expect_reg("cfg_rdata addr 3", 2'd3, 16'd0);
    check_residue("WORD_SHIFT_RES", residue_t'(shift_res), WORD_SHIFT_RES);

    // per-word mode, in_last set at random must be ignored
    send_word('0, 1'b0);
    send_word('1, 1'b1);
    send_word(word_t'(113), 1'b0);
    send_word(word_t'(112), 1'b1);
    send_word(word_t'(1) << 99, 1'b0);
    for (int i = 0; i < WORD_W; i++)
      send_word(word_t'(1) << i, 1'b0);
    for (int i = 0; i < N_RANDOM; i++)
    begin
      idle_cycles($urandom_range(0, MAX_GAP));
      send_word(random_word(), $urandom_range(0, 3) == 0);
    end
    drain_pipeline();
    expect_reg("cfg_rdata count", ADDR_COUNT, exp_count);
    expect_reg("cfg_rdata result", ADDR_RESULT, {9'd0, exp_result});
    write_ctrl(1'b0, 1'b1);
    expect_reg("cfg_rdata ctrl", ADDR_CTRL, 16'd0);
    expect_reg("cfg_rdata count", ADDR_COUNT, 16'd0);
    expect_reg("cfg_rdata result", ADDR_RESULT, 16'd0);

    write_ctrl(1'b1, 1'b0);
    expect_reg("cfg_rdata ctrl", ADDR_CTRL, 16'd1);
    for (int m = 0; m < N_MSG; m++)
    begin
      len = $urandom_range(1, MAX_LEN);
      for (int k = 0; k < len; k++)
      begin
        idle_cycles($urandom_range(0, MAX_GAP));
        send_word(random_word(), k == len - 1);
      end
      drain_pipeline();
      expect_reg("cfg_rdata count", ADDR_COUNT, exp_count);
      expect_reg("cfg_rdata result", ADDR_RESULT, {9'd0, exp_result});
      if (m % 5 == 4)
      begin
        write_ctrl(1'b1, 1'b1);
        expect_reg("cfg_rdata ctrl", ADDR_CTRL, 16'd1);
        expect_reg("cfg_rdata count", ADDR_COUNT, 16'd0);
        expect_reg("cfg_rdata result", ADDR_RESULT, 16'd0);
      end
    end

    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS = 4
)
(
  output logic clk
);

  initial
  begin
    clk = 1'b0;
    forever
      #(PERIOD_NS / 2) clk = ~clk;
  end

endmodule

`default_nettype wire

// ==== residue_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module residue_top
  import mod113_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      in_valid,
  input  word_t     in_word,
  input  logic      in_last,
  input  logic      cfg_wr,
  input  logic      cfg_rd,
  input  cfg_addr_t cfg_addr,
  input  cfg_data_t cfg_wdata,
  output logic      out_valid,
  output residue_t  out_residue,
  output logic      out_msg_done,
  output cfg_data_t cfg_rdata
);

  logic     res_valid;
  residue_t res;
  logic     res_last;

  acc_ctrl_if ctrl_if ();

  word_reducer u_reducer (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_word   (in_word),
    .in_last   (in_last),
    .res_valid (res_valid),
    .res       (res),
    .res_last  (res_last)
  );

  residue_accumulator u_acc (
    .clk          (clk),
    .reset        (reset),
    .res_valid    (res_valid),
    .res          (res),
    .res_last     (res_last),
    .ctrl         (ctrl_if.acc),
    .out_valid    (out_valid),
    .out_residue  (out_residue),
    .out_msg_done (out_msg_done)
  );

  residue_ctrl_regs u_regs (
    .clk       (clk),
    .reset     (reset),
    .cfg_wr    (cfg_wr),
    .cfg_rd    (cfg_rd),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .ctrl      (ctrl_if.regs)
  );

endmodule

`default_nettype wire

// ==== residue_ctrl_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module residue_ctrl_regs
  import mod113_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       cfg_wr,
  input  logic       cfg_rd,
  input  cfg_addr_t  cfg_addr,
  input  cfg_data_t  cfg_wdata,
  output cfg_data_t  cfg_rdata,
  acc_ctrl_if.regs   ctrl
);

  logic      accumulate;
  logic      clear_pulse;
  logic      ctrl_wr;
  cfg_data_t rd_mux;

  assign ctrl_wr = cfg_wr && (cfg_addr == ADDR_CTRL);

  // bit 1 of a CTRL write becomes a single clear pulse one cycle later
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      accumulate  <= 1'b0;
      clear_pulse <= 1'b0;
    end
    else
    begin
      clear_pulse <= ctrl_wr & cfg_wdata[1];
      if (ctrl_wr)
        accumulate <= cfg_wdata[0];
    end
  end

  always_comb
  begin
    case (cfg_addr)
      ADDR_CTRL:
        rd_mux = {15'd0, accumulate};
      ADDR_COUNT:
        rd_mux = ctrl.word_count;
      ADDR_RESULT:
        rd_mux = {9'd0, ctrl.last_result};
      default:
        rd_mux = '0;
    endcase
  end

  // read data holds until the next read strobe
  always_ff @(posedge clk)
  begin
    if (reset)
      cfg_rdata <= '0;
    else if (cfg_rd)
      cfg_rdata <= rd_mux;
  end

  assign ctrl.accumulate = accumulate;
  assign ctrl.clear      = clear_pulse;

endmodule

`default_nettype wire

// ==== residue_accumulator.sv ====
`timescale 1ns/1ps
`default_nettype none

module residue_accumulator
  import mod113_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      res_valid,
  input  residue_t  res,
  input  logic      res_last,
  acc_ctrl_if.acc   ctrl,
  output logic      out_valid,
  output residue_t  out_residue,
  output logic      out_msg_done
);

  residue_t    run_res;
  count_t      word_count;
  residue_t    last_result;
  logic [13:0] horner;
  logic [10:0] fold1;
  logic [8:0]  fold2;
  logic [7:0]  fold3;
  residue_t    acc_res;

  // run_res * 2^100 + res, at most 12320
  assign horner = 14'(run_res) * 14'(WORD_SHIFT_RES) + 14'(res);

  // three folds through 128 = 15 bring it below 158
  assign fold1 = 11'(horner[6:0]) + 11'(horner[13:7]) * 11'd15;
  assign fold2 = 9'(fold1[6:0]) + 9'(fold1[10:7]) * 9'd15;
  assign fold3 = 8'(fold2[6:0]) + 8'(fold2[8:7]) * 8'd15;

  assign acc_res = (fold3 >= 8'(MODULUS)) ? residue_t'(fold3 - 8'(MODULUS))
                                          : residue_t'(fold3);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      out_valid    <= 1'b0;
      out_msg_done <= 1'b0;
      run_res      <= '0;
      word_count   <= '0;
      last_result  <= '0;
    end
    else
    begin
      out_valid    <= res_valid;
      out_msg_done <= res_valid & res_last & ctrl.accumulate;
      if (ctrl.clear)
      begin
        run_res     <= '0;
        word_count  <= '0;
        last_result <= '0;
      end
      else if (res_valid)
      begin
        word_count <= word_count + 16'd1;
        if (!ctrl.accumulate)
        begin
          run_res     <= '0;
          last_result <= res;
        end
        else if (res_last)
        begin
          // message ends here, the next word starts a new one
          run_res     <= '0;
          last_result <= acc_res;
        end
        else
          run_res <= acc_res;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (res_valid)
      out_residue <= ctrl.accumulate ? acc_res : res;
  end

  assign ctrl.word_count  = word_count;
  assign ctrl.last_result = last_result;

endmodule

`default_nettype wire

// ==== word_reducer.sv ====
`timescale 1ns/1ps
`default_nettype none

module word_reducer
  import mod113_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     in_valid,
  input  word_t    in_word,
  input  logic     in_last,
  output logic     res_valid,
  output residue_t res,
  output logic     res_last
);

  residue_t lut_res [1:N_CHUNKS];

  // the low 6 bits have weight 1 and skip the lookup
  for (genvar k = 1; k <= N_CHUNKS; k++)
  begin : g_lut
    logic [CHUNK_W-1:0] chunk;

    if (k < N_CHUNKS)
    begin : g_full
      assign chunk = in_word[CHUNK_W*k +: CHUNK_W];
    end
    else
    begin : g_top
      assign chunk = {2'b00, in_word[WORD_W-1:CHUNK_W*k]};
    end

    chunk_residue_lut #(
      .CHUNK_IDX (k)
    ) u_lut (
      .chunk (chunk),
      .res   (lut_res[k])
    );
  end

  logic [8:0] tri_sum [0:4];
  logic [9:0] psum_a;
  logic [9:0] psum_b;

  assign tri_sum[0] = 9'(lut_res[1]) + 9'(lut_res[2]) + 9'(lut_res[3]);
  assign tri_sum[1] = 9'(lut_res[4]) + 9'(lut_res[5]) + 9'(lut_res[6]);
  assign tri_sum[2] = 9'(lut_res[7]) + 9'(lut_res[8]) + 9'(lut_res[9]);
  assign tri_sum[3] = 9'(lut_res[10]) + 9'(lut_res[11]) + 9'(lut_res[12]);
  assign tri_sum[4] = 9'(lut_res[13]) + 9'(lut_res[14]) + 9'(lut_res[15]);

  assign psum_a = 10'(tri_sum[0]) + 10'(tri_sum[1]) + 10'(tri_sum[2]);
  assign psum_b = 10'(tri_sum[3]) + 10'(tri_sum[4]) + 10'(lut_res[16]);

  logic               s1_valid;
  logic               s1_last;
  logic [9:0]         psum_a_q;
  logic [9:0]         psum_b_q;
  logic [CHUNK_W-1:0] raw_q;

  always_ff @(posedge clk)
  begin
    if (reset)
      s1_valid <= 1'b0;
    else
      s1_valid <= in_valid;
  end

  always_ff @(posedge clk)
  begin
    s1_last  <= in_last;
    psum_a_q <= psum_a;
    psum_b_q <= psum_b;
    raw_q    <= in_word[CHUNK_W-1:0];
  end

  // bit 6 keeps its weight of 64, bits above fold through 128 = 15 (mod 113)
  function automatic logic [7:0] fold_psum(input logic [9:0] p);
    fold_psum = 8'(p[5:0]) + 8'(p[6]) * 8'd64 + 8'(p[9:7]) * 8'd15;
  endfunction

  logic [8:0] fold_sum;
  logic [7:0] fold_fin;
  residue_t   res_next;

  assign fold_sum = 9'(fold_psum(psum_a_q)) + 9'(fold_psum(psum_b_q));

  // the second fold stays below 226, so one subtraction is enough
  assign fold_fin = 8'(fold_sum[5:0]) + 8'(fold_sum[6]) * 8'd64
                  + 8'(fold_sum[8:7]) * 8'd15 + 8'(raw_q);

  assign res_next = (fold_fin >= 8'(MODULUS)) ? residue_t'(fold_fin - 8'(MODULUS))
                                              : residue_t'(fold_fin);

  always_ff @(posedge clk)
  begin
    if (reset)
      res_valid <= 1'b0;
    else
      res_valid <= s1_valid;
  end

  always_ff @(posedge clk)
  begin
    res      <= res_next;
    res_last <= s1_last;
  end

endmodule

`default_nettype wire

// ==== chunk_residue_lut.sv ====
`timescale 1ns/1ps
`default_nettype none

module chunk_residue_lut
  import mod113_pkg::*;
#(
  parameter int CHUNK_IDX = 1
)
(
  input  logic [CHUNK_W-1:0] chunk,
  output residue_t           res
);

  localparam residue_t WEIGHT = CHUNK_WEIGHT[CHUNK_IDX];

  // 63 * 112 needs 13 bits
  logic [12:0] product;
  logic [12:0] reduced;

  // with a constant weight this collapses to a 64-entry table
  assign product = 13'(chunk) * 13'(WEIGHT);
  assign reduced = product % 13'(MODULUS);
  assign res     = residue_t'(reduced);

endmodule

`default_nettype wire

// ==== acc_ctrl_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface acc_ctrl_if
  import mod113_pkg::*;
();

  logic     accumulate;
  logic     clear;
  count_t   word_count;
  residue_t last_result;

  modport regs (
    output accumulate,
    output clear,
    input  word_count,
    input  last_result
  );

  modport acc (
    input  accumulate,
    input  clear,
    output word_count,
    output last_result
  );

endinterface

`default_nettype wire

// ==== mod113_pkg.sv ====
`default_nettype none

package mod113_pkg;

  localparam logic [6:0] MODULUS  = 7'd113;
  localparam int         WORD_W   = 100;
  localparam int         RES_W    = 7;
  localparam int         CHUNK_W  = 6;
  localparam int         N_CHUNKS = 16;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [RES_W-1:0]  residue_t;
  typedef logic [15:0]       count_t;
  typedef logic [1:0]        cfg_addr_t;
  typedef logic [15:0]       cfg_data_t;

  // 2^(6k) mod 113 for k = 1..16, the order of 2 is 28 so the table repeats
  localparam residue_t CHUNK_WEIGHT [1:N_CHUNKS] = '{
    7'd64,  7'd28,  7'd97,  7'd106,
    7'd4,   7'd30,  7'd112, 7'd49,
    7'd85,  7'd16,  7'd7,   7'd109,
    7'd83,  7'd1,   7'd64,  7'd28
  };

  // 2^100 mod 113, the weight of one whole word in a message
  localparam residue_t WORD_SHIFT_RES = 7'd109;

  localparam cfg_addr_t ADDR_CTRL   = 2'd0;
  localparam cfg_addr_t ADDR_COUNT  = 2'd1;
  localparam cfg_addr_t ADDR_RESULT = 2'd2;

endpackage

`default_nettype wire
